/* core_pkg.sv */
package core_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ = 6'h04;
    localparam logic [5:0] OP_BNE = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI = 6'h0d;
    localparam logic [5:0] OP_LUI = 6'h0f;
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b;

    // funct field under OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
    } fd_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs_val;
        logic [XLEN-1:0]   rt_val;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] dest;
        alu_op_e           alu_op;
        logic              use_imm;
        logic              reg_we;
        logic              is_load;
        logic              is_store;
        logic              is_beq;
        logic              is_bne;
    } de_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   result;
        logic [REG_AW-1:0] dest;
        logic              reg_we;
        logic              is_load;
    } ew_t;

endpackage

/* decoder.sv */
`timescale 1ns/1ns
module decoder import core_pkg::*; (
    input  logic [XLEN-1:0]   inst_i,
    output logic [REG_AW-1:0] rs_o,
    output logic [REG_AW-1:0] rt_o,
    output logic [REG_AW-1:0] dest_o,
    output logic [XLEN-1:0]   imm_o,
    output alu_op_e           alu_op_o,
    output logic              use_imm_o,
    output logic              reg_we_o,
    output logic              is_load_o,
    output logic              is_store_o,
    output logic              is_beq_o,
    output logic              is_bne_o,
    output logic              uses_rt_o
);

    logic [5:0]      opcode;
    logic [5:0]      funct;
    logic [15:0]     imm16;
    logic [XLEN-1:0] imm_sext;
    logic            writes;
    logic            dest_is_rd;

    assign opcode = inst_i[31:26];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[15:0];
    assign rs_o = inst_i[25:21];
    assign rt_o = inst_i[20:16];
    assign imm_sext = {{(XLEN-16){imm16[15]}}, imm16};

    always_comb begin
        alu_op_o = ALU_ADD;
        imm_o = imm_sext;
        use_imm_o = 1'b0;
        writes = 1'b0;
        dest_is_rd = 1'b0;
        uses_rt_o = 1'b0;
        is_load_o = 1'b0;
        is_store_o = 1'b0;
        is_beq_o = 1'b0;
        is_bne_o = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dest_is_rd = 1'b1;
                uses_rt_o = 1'b1;
                writes = 1'b1;
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    default: begin
                        writes = 1'b0;
                        uses_rt_o = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                use_imm_o = 1'b1;
                writes = 1'b1;
            end
            OP_ORI: begin
                alu_op_o = ALU_OR;
                imm_o = {{(XLEN-16){1'b0}}, imm16};
                use_imm_o = 1'b1;
                writes = 1'b1;
            end
            OP_LUI: begin
                alu_op_o = ALU_LUI;
                imm_o = {imm16, {(XLEN-16){1'b0}}};
                use_imm_o = 1'b1;
                writes = 1'b1;
            end
            OP_LW: begin
                use_imm_o = 1'b1;
                writes = 1'b1;
                is_load_o = 1'b1;
            end
            OP_SW: begin
                use_imm_o = 1'b1;
                uses_rt_o = 1'b1;
                is_store_o = 1'b1;
            end
            OP_BEQ: begin
                uses_rt_o = 1'b1;
                is_beq_o = 1'b1;
            end
            OP_BNE: begin
                uses_rt_o = 1'b1;
                is_bne_o = 1'b1;
            end
            // unknown opcode stays a no-op
            default: ;
        endcase
    end

    assign dest_o = dest_is_rd ? inst_i[15:11] : rt_o;
    // writes to $0 are dropped here
    assign reg_we_o = writes & (dest_o != '0);

endmodule

/* execute.sv */
`timescale 1ns/1ns
module execute import core_pkg::*; (
    input  logic            e_valid_i,
    input  de_t             e_data_i,
    input  logic            fwd_a_i,
    input  logic            fwd_b_i,
    input  logic [XLEN-1:0] w_value_i,
    output logic [XLEN-1:0] result_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] target_o,
    output logic            data_sram_en_o,
    output logic [3:0]      data_sram_wen_o,
    output logic [XLEN-1:0] data_sram_addr_o,
    output logic [XLEN-1:0] data_sram_wdata_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic            equal;

    assign op_a = fwd_a_i ? w_value_i : e_data_i.rs_val;
    assign op_b = fwd_b_i ? w_value_i : e_data_i.rt_val;
    assign alu_b = e_data_i.use_imm ? e_data_i.imm : op_b;

    always_comb begin
        case (e_data_i.alu_op)
            ALU_SUB: result_o = op_a - alu_b;
            ALU_AND: result_o = op_a & alu_b;
            ALU_OR:  result_o = op_a | alu_b;
            ALU_XOR: result_o = op_a ^ alu_b;
            ALU_SLT: result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            ALU_LUI: result_o = alu_b;
            default: result_o = op_a + alu_b;
        endcase
    end

    // no delay slot, so the target is relative to the next word
    assign equal = op_a == op_b;
    assign redirect_o = e_valid_i & ((e_data_i.is_beq & equal) | (e_data_i.is_bne & ~equal));
    assign target_o = e_data_i.pc + XLEN'(4) + {e_data_i.imm[XLEN-3:0], 2'b00};

    // word access only, address is rs + offset
    assign data_sram_en_o = e_valid_i & (e_data_i.is_load | e_data_i.is_store);
    assign data_sram_wen_o = {4{e_valid_i & e_data_i.is_store}};
    assign data_sram_addr_o = result_o;
    assign data_sram_wdata_o = op_b;

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ns
module hazard_unit import core_pkg::*; (
    input  logic              d_valid_i,
    input  logic [REG_AW-1:0] d_rs_i,
    input  logic [REG_AW-1:0] d_rt_i,
    input  logic              d_uses_rt_i,
    input  logic              e_valid_i,
    input  logic              e_is_load_i,
    input  logic [REG_AW-1:0] e_dest_i,
    input  logic [REG_AW-1:0] e_rs_i,
    input  logic [REG_AW-1:0] e_rt_i,
    input  logic              w_valid_i,
    input  logic              w_reg_we_i,
    input  logic [REG_AW-1:0] w_dest_i,
    output logic              stall_o,
    output logic              fwd_a_o,
    output logic              fwd_b_o
);

    logic load_in_ex;
    logic hit_rs;
    logic hit_rt;
    logic w_writes;

    // load in execute feeding the instruction in decode
    assign load_in_ex = e_valid_i & e_is_load_i & (e_dest_i != '0);
    assign hit_rs = e_dest_i == d_rs_i;
    assign hit_rt = d_uses_rt_i & (e_dest_i == d_rt_i);
    assign stall_o = d_valid_i & load_in_ex & (hit_rs | hit_rt);

    // writeback to execute bypass
    assign w_writes = w_valid_i & w_reg_we_i & (w_dest_i != '0);
    assign fwd_a_o = w_writes & (w_dest_i == e_rs_i);
    assign fwd_b_o = w_writes & (w_dest_i == e_rt_i);

endmodule

/* mips_core.sv */
`timescale 1ns/1ns
module mips_core import core_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    output logic              inst_sram_en_o,
    output logic [XLEN-1:0]   inst_sram_addr_o,
    input  logic [XLEN-1:0]   inst_sram_rdata_i,
    output logic              data_sram_en_o,
    output logic [3:0]        data_sram_wen_o,
    output logic [XLEN-1:0]   data_sram_addr_o,
    output logic [XLEN-1:0]   data_sram_wdata_o,
    input  logic [XLEN-1:0]   data_sram_rdata_i,
    output logic [XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]        debug_wb_rf_wen_o,
    output logic [REG_AW-1:0] debug_wb_rf_wnum_o,
    output logic [XLEN-1:0]   debug_wb_rf_wdata_o
);

    logic              stall;
    logic              redirect;
    logic [XLEN-1:0]   target;
    logic              fd_valid;
    logic              de_valid;
    logic              ew_valid;
    logic [REG_AW-1:0] d_rs;
    logic [REG_AW-1:0] d_rt;
    logic              d_uses_rt;
    logic              fwd_a;
    logic              fwd_b;
    logic [XLEN-1:0]   w_value;
    logic              rf_we;
    fd_t               fd_in;
    fd_t               fd_q;
    de_t               de_in;
    de_t               de_q;
    ew_t               ew_in;
    ew_t               ew_q;

    pc_gen pc_gen_inst (
        .clk              (clk),
        .rst              (rst),
        .stall_i          (stall),
        .redirect_i       (redirect),
        .target_i         (target),
        .pc_o             (fd_in.pc),
        .inst_sram_en_o   (inst_sram_en_o),
        .inst_sram_addr_o (inst_sram_addr_o)
    );

    stage_reg #(.payload_t(fd_t)) fd_reg_inst (
        .clk     (clk),
        .rst     (rst),
        .hold_i  (stall),
        .flush_i (redirect),
        .valid_i (inst_sram_en_o),
        .data_i  (fd_in),
        .valid_o (fd_valid),
        .data_o  (fd_q)
    );

    // decode works on the sram output directly
    assign de_in.pc = fd_q.pc;

    decoder decoder_inst (
        .inst_i     (inst_sram_rdata_i),
        .rs_o       (d_rs),
        .rt_o       (d_rt),
        .dest_o     (de_in.dest),
        .imm_o      (de_in.imm),
        .alu_op_o   (de_in.alu_op),
        .use_imm_o  (de_in.use_imm),
        .reg_we_o   (de_in.reg_we),
        .is_load_o  (de_in.is_load),
        .is_store_o (de_in.is_store),
        .is_beq_o   (de_in.is_beq),
        .is_bne_o   (de_in.is_bne),
        .uses_rt_o  (d_uses_rt)
    );

    assign de_in.rs = d_rs;
    assign de_in.rt = d_rt;

    regfile regfile_inst (
        .clk       (clk),
        .rst       (rst),
        .we_i      (rf_we),
        .waddr_i   (ew_q.dest),
        .wdata_i   (w_value),
        .raddr_a_i (d_rs),
        .raddr_b_i (d_rt),
        .rdata_a_o (de_in.rs_val),
        .rdata_b_o (de_in.rt_val)
    );

    hazard_unit hazard_unit_inst (
        .d_valid_i   (fd_valid),
        .d_rs_i      (d_rs),
        .d_rt_i      (d_rt),
        .d_uses_rt_i (d_uses_rt),
        .e_valid_i   (de_valid),
        .e_is_load_i (de_q.is_load),
        .e_dest_i    (de_q.dest),
        .e_rs_i      (de_q.rs),
        .e_rt_i      (de_q.rt),
        .w_valid_i   (ew_valid),
        .w_reg_we_i  (ew_q.reg_we),
        .w_dest_i    (ew_q.dest),
        .stall_o     (stall),
        .fwd_a_o     (fwd_a),
        .fwd_b_o     (fwd_b)
    );

    // a stalled instruction leaves a bubble behind it
    stage_reg #(.payload_t(de_t)) de_reg_inst (
        .clk     (clk),
        .rst     (rst),
        .hold_i  (1'b0),
        .flush_i (redirect),
        .valid_i (fd_valid & ~stall),
        .data_i  (de_in),
        .valid_o (de_valid),
        .data_o  (de_q)
    );

    execute execute_inst (
        .e_valid_i         (de_valid),
        .e_data_i          (de_q),
        .fwd_a_i           (fwd_a),
        .fwd_b_i           (fwd_b),
        .w_value_i         (w_value),
        .result_o          (ew_in.result),
        .redirect_o        (redirect),
        .target_o          (target),
        .data_sram_en_o    (data_sram_en_o),
        .data_sram_wen_o   (data_sram_wen_o),
        .data_sram_addr_o  (data_sram_addr_o),
        .data_sram_wdata_o (data_sram_wdata_o)
    );

    assign ew_in.pc = de_q.pc;
    assign ew_in.dest = de_q.dest;
    assign ew_in.reg_we = de_q.reg_we;
    assign ew_in.is_load = de_q.is_load;

    stage_reg #(.payload_t(ew_t)) ew_reg_inst (
        .clk     (clk),
        .rst     (rst),
        .hold_i  (1'b0),
        .flush_i (1'b0),
        .valid_i (de_valid),
        .data_i  (ew_in),
        .valid_o (ew_valid),
        .data_o  (ew_q)
    );

    // load data lands while the load sits in writeback
    assign w_value = ew_q.is_load ? data_sram_rdata_i : ew_q.result;
    assign rf_we = ew_valid & ew_q.reg_we;

    assign debug_wb_pc_o = ew_q.pc;
    assign debug_wb_rf_wen_o = {4{rf_we}};
    assign debug_wb_rf_wnum_o = ew_q.dest;
    assign debug_wb_rf_wdata_o = w_value;

endmodule

/* pc_gen.sv */
`timescale 1ns/1ns
module pc_gen import core_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] target_i,
    output logic [XLEN-1:0] pc_o,
    output logic            inst_sram_en_o,
    output logic [XLEN-1:0] inst_sram_addr_o
);

    logic            run_q;
    logic [XLEN-1:0] pc_q;

    // fetching starts one cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (inst_sram_en_o) begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    // a held fetch keeps the sram output, so decode sees the same word
    assign inst_sram_en_o = run_q & (redirect_i | ~stall_i);
    assign inst_sram_addr_o = pc_q;
    assign pc_o = pc_q;

endmodule

/* project.f */
core_pkg.sv
stage_reg.sv
pc_gen.sv
decoder.sv
regfile.sv
hazard_unit.sv
execute.sv
mips_core.sv
tb_mips_core_checker.sv
tb_mips_core.sv

/* regfile.sv */
`timescale 1ns/1ns
module regfile import core_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i,
    input  logic [REG_AW-1:0] raddr_a_i,
    input  logic [REG_AW-1:0] raddr_b_i,
    output logic [XLEN-1:0]   rdata_a_o,
    output logic [XLEN-1:0]   rdata_b_o
);

    logic [XLEN-1:0] regs [1:2**REG_AW-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // $0 reads zero, a same-cycle write passes straight through
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    assign rdata_a_o = read_port(raddr_a_i);
    assign rdata_b_o = read_port(raddr_b_i);

endmodule

/* run.sh */
#!/bin/sh
# build and run the testbench; exit status follows the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_mips_core -f project.f -o tb_mips_core &&
./obj_dir/tb_mips_core +verilator+error+limit+100 | tee /dev/stderr | grep -q "TEST PASSED" ||
exit 1

/* stage_reg.sv */
`timescale 1ns/1ns
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // flush beats hold
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_o <= 1'b0;
        end else if (!hold_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            data_o <= data_i;
        end
    end

endmodule

/* tb_mips_core.sv */
`timescale 1ns/1ns
module tb_mips_core import core_pkg::*; ();

    localparam int WB_TIMEOUT = 20;
    localparam int QUIET_CYCLES = 12;

    logic              clk = 1'b0;
    logic              rst;
    logic              inst_sram_en;
    logic [XLEN-1:0]   inst_sram_addr;
    logic [XLEN-1:0]   inst_sram_rdata = '0;
    logic              data_sram_en;
    logic [3:0]        data_sram_wen;
    logic [XLEN-1:0]   data_sram_addr;
    logic [XLEN-1:0]   data_sram_wdata;
    logic [XLEN-1:0]   data_sram_rdata = '0;
    logic [XLEN-1:0]   debug_wb_pc;
    logic [3:0]        debug_wb_rf_wen;
    logic [REG_AW-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]   debug_wb_rf_wdata;

    logic [XLEN-1:0]   program_q [$];
    logic [XLEN-1:0]   dmem [0:63];
    logic [XLEN-1:0]   exp_pc [$];
    logic [REG_AW-1:0] exp_reg [$];
    logic [XLEN-1:0]   exp_val [$];
    int                errors;

    // sram requests captured mid-cycle
    logic              fetch_req = 1'b0;
    logic [XLEN-1:0]   fetch_addr = '0;
    logic              mem_req = 1'b0;
    logic              mem_write = 1'b0;
    logic [XLEN-1:0]   mem_addr = '0;
    logic [XLEN-1:0]   mem_wdata = '0;

    always #50 clk = ~clk;

    mips_core mips_core_inst (
        .clk                 (clk),
        .rst                 (rst),
        .inst_sram_en_o      (inst_sram_en),
        .inst_sram_addr_o    (inst_sram_addr),
        .inst_sram_rdata_i   (inst_sram_rdata),
        .data_sram_en_o      (data_sram_en),
        .data_sram_wen_o     (data_sram_wen),
        .data_sram_addr_o    (data_sram_addr),
        .data_sram_wdata_o   (data_sram_wdata),
        .data_sram_rdata_i   (data_sram_rdata),
        .debug_wb_pc_o       (debug_wb_pc),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata)
    );

    function automatic logic [XLEN-1:0] r_type(input logic [5:0] funct, input int rd,
                                               input int rs, input int rt);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [XLEN-1:0] i_type(input logic [5:0] op, input int rt,
                                               input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // past the end of the program reads as a no-op
    function automatic logic [XLEN-1:0] read_program(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'(addr[XLEN-1:2]);
        if (idx < program_q.size()) begin
            return program_q[idx];
        end
        return '0;
    endfunction

    always @(negedge clk) begin
        fetch_req = inst_sram_en;
        fetch_addr = inst_sram_addr;
        mem_req = data_sram_en;
        mem_write = data_sram_wen == 4'hf;
        mem_addr = data_sram_addr;
        mem_wdata = data_sram_wdata;
    end

    // both srams answer just after the edge; a disabled sram keeps its output
    always @(posedge clk) begin
        #1;
        if (fetch_req === 1'b1) begin
            inst_sram_rdata <= read_program(fetch_addr);
        end
        if (mem_req === 1'b1) begin
            if (mem_write) begin
                dmem[mem_addr[7:2]] <= mem_wdata;
            end else begin
                data_sram_rdata <= dmem[mem_addr[7:2]];
            end
        end
    end

    task automatic load_program();
        program_q.push_back(i_type(OP_ADDIU, 1, 0, 5));
        program_q.push_back(i_type(OP_ADDIU, 2, 1, -3));
        program_q.push_back(i_type(OP_ORI, 3, 2, 'hf0f0));
        program_q.push_back(i_type(OP_LUI, 4, 0, 'h1234));
        program_q.push_back(r_type(FN_ADDU, 5, 4, 3));
        program_q.push_back(r_type(FN_SUBU, 6, 1, 2));
        program_q.push_back(r_type(FN_AND, 7, 5, 3));
        program_q.push_back(r_type(FN_OR, 8, 6, 4));
        program_q.push_back(r_type(FN_XOR, 9, 8, 5));
        program_q.push_back(r_type(FN_SLT, 10, 2, 1));
        program_q.push_back(i_type(OP_ADDIU, 11, 0, -1));
        program_q.push_back(r_type(FN_SLT, 12, 11, 1));
        // write to $0 must not stick
        program_q.push_back(i_type(OP_ADDIU, 0, 0, 7));
        program_q.push_back(r_type(FN_ADDU, 13, 0, 1));
        program_q.push_back(i_type(OP_SW, 5, 0, 'h40));
        program_q.push_back(i_type(OP_LW, 14, 0, 'h40));
        program_q.push_back(r_type(FN_ADDU, 15, 14, 1));
        // taken beq skips two, taken bne skips one
        program_q.push_back(i_type(OP_BEQ, 13, 1, 2));
        program_q.push_back(i_type(OP_ADDIU, 16, 0, 'h111));
        program_q.push_back(i_type(OP_ADDIU, 17, 0, 'h222));
        program_q.push_back(i_type(OP_BNE, 2, 1, 1));
        program_q.push_back(i_type(OP_ADDIU, 18, 0, 'h333));
        program_q.push_back(i_type(OP_BNE, 13, 1, 5));
        program_q.push_back(i_type(OP_ADDIU, 19, 0, 'h444));
        // park in a self loop
        program_q.push_back(i_type(OP_BEQ, 0, 0, -1));
        program_q.push_back(i_type(OP_ADDIU, 20, 0, 'h555));
    endtask

    task automatic expect_write(input logic [XLEN-1:0] pc, input int r,
                                input logic [XLEN-1:0] value);
        exp_pc.push_back(pc);
        exp_reg.push_back(5'(r));
        exp_val.push_back(value);
    endtask

    task automatic load_expected();
        expect_write(32'h0000_0000, 1, 32'h0000_0005);
        expect_write(32'h0000_0004, 2, 32'h0000_0002);
        expect_write(32'h0000_0008, 3, 32'h0000_f0f2);
        expect_write(32'h0000_000c, 4, 32'h1234_0000);
        expect_write(32'h0000_0010, 5, 32'h1234_f0f2);
        expect_write(32'h0000_0014, 6, 32'h0000_0003);
        expect_write(32'h0000_0018, 7, 32'h0000_f0f2);
        expect_write(32'h0000_001c, 8, 32'h1234_0003);
        expect_write(32'h0000_0020, 9, 32'h0000_f0f1);
        expect_write(32'h0000_0024, 10, 32'h0000_0001);
        expect_write(32'h0000_0028, 11, 32'hffff_ffff);
        expect_write(32'h0000_002c, 12, 32'h0000_0001);
        expect_write(32'h0000_0034, 13, 32'h0000_0005);
        expect_write(32'h0000_003c, 14, 32'h1234_f0f2);
        expect_write(32'h0000_0040, 15, 32'h1234_f0f7);
        expect_write(32'h0000_005c, 19, 32'h0000_0444);
    endtask

    task automatic wait_writeback(output bit seen);
        int waited;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < WB_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (debug_wb_rf_wen == 4'hf) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic check_no_more_writes();
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            assert (debug_wb_rf_wen == 4'h0)
            else begin
                errors++;
                $display("ERR %0t: unexpected write of %h to r%0d", $time,
                         debug_wb_rf_wdata, debug_wb_rf_wnum);
            end
        end
    endtask

    initial begin
        bit seen;
        bit timed_out;
        int checker_errors;
        rst = 1'b1;
        errors = 0;
        timed_out = 1'b0;
        load_program();
        load_expected();
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        for (int i = 0; i < exp_reg.size() && !timed_out; i++) begin
            wait_writeback(seen);
            if (!seen) begin
                errors++;
                timed_out = 1'b1;
                $display("writeback did not arrive: r%0d still missing after %0d cycles",
                         exp_reg[i], WB_TIMEOUT);
            end else begin
                assert (debug_wb_pc == exp_pc[i] && debug_wb_rf_wnum == exp_reg[i] &&
                        debug_wb_rf_wdata == exp_val[i])
                else begin
                    errors++;
                    $display("ERR %0t: pc %h r%0d = %h, expected pc %h r%0d = %h", $time,
                             debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                             exp_pc[i], exp_reg[i], exp_val[i]);
                end
            end
        end
        if (!timed_out) begin
            check_no_more_writes();
        end

        checker_errors = mips_core_inst.port_checker_inst.fail_count;
        $display("writeback errors: %0d, checker errors: %0d", errors, checker_errors);
        if (errors == 0 && checker_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb_mips_core_checker.sv */
`timescale 1ns/1ns
module tb_mips_core_checker import core_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              inst_en_i,
    input logic [XLEN-1:0]   inst_addr_i,
    input logic              data_en_i,
    input logic [3:0]        data_wen_i,
    input logic [3:0]        wb_wen_i,
    input logic [REG_AW-1:0] wb_wnum_i
);

    int fail_count = 0;

    // nothing reaches memory or the register file in reset and one cycle after
    reset_quiet: assert property (@(posedge clk) rst |=> (!data_en_i && wb_wen_i == 4'h0))
        else begin
            fail_count++;
            $error("data sram or register write active during reset");
        end

    first_fetch: assert property (@(posedge clk) $fell(rst) |=>
                                  (inst_en_i && inst_addr_i == RESET_PC))
        else begin
            fail_count++;
            $error("first fetch after reset is not at the reset pc");
        end

    no_zero_write: assert property (@(posedge clk) disable iff (rst)
                                    wb_wen_i != 4'h0 |-> wb_wnum_i != '0)
        else begin
            fail_count++;
            $error("debug port shows a write to register zero");
        end

    wen_shape: assert property (@(posedge clk) disable iff (rst)
                                data_wen_i == 4'h0 || (data_wen_i == 4'hf && data_en_i))
        else begin
            fail_count++;
            $error("data sram write enable is partial or lacks the enable");
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (rst) inst_addr_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("instruction address is not word aligned");
        end

endmodule

bind mips_core tb_mips_core_checker port_checker_inst (
    .clk         (clk),
    .rst         (rst),
    .inst_en_i   (inst_sram_en_o),
    .inst_addr_i (inst_sram_addr_o),
    .data_en_i   (data_sram_en_o),
    .data_wen_i  (data_sram_wen_o),
    .wb_wen_i    (debug_wb_rf_wen_o),
    .wb_wnum_i   (debug_wb_rf_wnum_o)
);
